// File: include/ppu_macros.svh
`ifndef PPU_MACROS_SVH
`define PPU_MACROS_SVH

// Line and frame timing, in dots and lines
`define PPU_H_TOTAL       456
`define PPU_V_TOTAL       154
`define PPU_V_ACTIVE      144
`define PPU_H_OAM         80   // Mode 2 ends here, mode 3 starts

// Sync pulses
`define PPU_H_SYNC_START  76
`define PPU_H_SYNC_LEN    4
`define PPU_V_SYNC_START  153
`define PPU_V_SYNC_LEN    1

`define PPU_H_PIXELS      160

// Memory and CPU address windows
`define PPU_VRAM_AW       13
`define PPU_REG_BASE      16'hFF40
`define PPU_REG_LAST      16'hFF4B
`define PPU_VRAM_BASE     16'h8000
`define PPU_VRAM_LAST     16'h9FFF

// Palette after reset
`define PPU_BGP_RESET     8'hFC

`endif

// File: rtl/ppu_pkg.sv
package ppu_pkg;

    // STAT mode field encoding
    typedef enum logic [1:0] {
        HBLANK = 2'd0,
        VBLANK = 2'd1,
        OAM    = 2'd2,
        XFER   = 2'd3
    } ppu_mode_e;

    typedef logic [1:0] pix_t;      // Colour index or shade

    // One decoded tile row, element 7 is the leftmost pixel
    typedef pix_t [7:0] tile_row_t;

    // Register offsets inside FF40..FF4B
    typedef enum logic [3:0] {
        REG_LCDC = 4'h0,
        REG_STAT = 4'h1,
        REG_SCY  = 4'h2,
        REG_SCX  = 4'h3,
        REG_LY   = 4'h4,
        REG_LYC  = 4'h5,
        REG_DMA  = 4'h6,
        REG_BGP  = 4'h7,
        REG_OBP0 = 4'h8,
        REG_OBP1 = 4'h9,
        REG_WY   = 4'hA,
        REG_WX   = 4'hB
    } reg_idx_e;

endpackage

// File: rtl/ppu_cfg_if.sv
`timescale 1ns/10ps

// Static control levels from the register block
interface ppu_cfg_if;
    logic       lcd_en;         // LCDC bit 7
    logic       bg_en;          // LCDC bit 0
    logic       bg_map_sel;     // LCDC bit 3, 0=9800 1=9C00
    logic       tile_data_sel;  // LCDC bit 4, 1=8000 unsigned
    logic [7:0] scx;
    logic [7:0] scy;
    logic [7:0] bgp;

    modport regs (
        output lcd_en, bg_en, bg_map_sel, tile_data_sel, scx, scy, bgp
    );

    modport timing (
        input lcd_en
    );

    modport render (
        input lcd_en, bg_en, bg_map_sel, tile_data_sel, scx, scy, bgp
    );
endinterface

// File: rtl/ppu_regs.sv
`timescale 1ns/10ps
`include "ppu_macros.svh"

module ppu_regs import ppu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic [7:0]  wdata,
    input  logic        wr,
    output logic [7:0]  reg_rdata,
    ppu_cfg_if.regs     cfg,
    input  logic [7:0]  ly,
    input  ppu_mode_e   mode,
    output logic        int_vblank_req,
    output logic        int_stat_req,
    input  logic        int_vblank_ack,
    input  logic        int_stat_ack
);
    logic [7:0] lcdc;
    logic [4:0] stat_hi;    // STAT bits 7..3
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] dma;        // Storage only
    logic [7:0] bgp;
    logic [7:0] obp0;
    logic [7:0] obp1;
    logic [7:0] wy;
    logic [7:0] wx;

    logic       in_win;
    reg_idx_e   idx;
    logic       coin;
    logic [7:0] ly_q;
    ppu_mode_e  mode_q;
    logic       mode_chg;
    logic       ly_chg;
    logic [1:0] irq_evt;    // [0] vblank, [1] stat
    logic [1:0] irq_ack;
    logic [1:0] irq_req;
    logic [1:0] irq_pend;   // Event seen while ack was high

    assign in_win = (addr >= `PPU_REG_BASE) && (addr <= `PPU_REG_LAST);
    assign idx    = reg_idx_e'(addr[3:0]);
    assign coin   = (ly == lyc);

    assign cfg.lcd_en        = lcdc[7];
    assign cfg.bg_en         = lcdc[0];
    assign cfg.bg_map_sel    = lcdc[3];
    assign cfg.tile_data_sel = lcdc[4];
    assign cfg.scx           = scx;
    assign cfg.scy           = scy;
    assign cfg.bgp           = bgp;

    //////////////////////////////////////////////////////////////////////
    // CPU access

    always_comb begin
        reg_rdata = 8'hFF;
        if (in_win) begin
            case (idx)
                REG_LCDC: reg_rdata = lcdc;
                REG_STAT: reg_rdata = {stat_hi, coin, mode};
                REG_SCY:  reg_rdata = scy;
                REG_SCX:  reg_rdata = scx;
                REG_LY:   reg_rdata = ly;
                REG_LYC:  reg_rdata = lyc;
                REG_DMA:  reg_rdata = dma;
                REG_BGP:  reg_rdata = bgp;
                REG_OBP0: reg_rdata = obp0;
                REG_OBP1: reg_rdata = obp1;
                REG_WY:   reg_rdata = wy;
                REG_WX:   reg_rdata = wx;
                default:  reg_rdata = 8'hFF;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= 8'h00;   // LCD off
            stat_hi <= 5'h00;
            scy     <= 8'h00;
            scx     <= 8'h00;
            lyc     <= 8'h00;
            dma     <= 8'h00;
            bgp     <= `PPU_BGP_RESET;
            obp0    <= 8'h00;
            obp1    <= 8'h00;
            wy      <= 8'h00;
            wx      <= 8'h00;
        end else if (wr && in_win) begin
            case (idx)
                REG_LCDC: lcdc    <= wdata;
                REG_STAT: stat_hi <= wdata[7:3];
                REG_SCY:  scy     <= wdata;
                REG_SCX:  scx     <= wdata;
                REG_LYC:  lyc     <= wdata;
                REG_DMA:  dma     <= wdata;
                REG_BGP:  bgp     <= wdata;
                REG_OBP0: obp0    <= wdata;
                REG_OBP1: obp1    <= wdata;
                REG_WY:   wy      <= wdata;
                REG_WX:   wx      <= wdata;
                default: ;          // LY is read only
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Interrupt sources and request/acknowledge

    assign mode_chg = (mode != mode_q);
    assign ly_chg   = (ly != ly_q);

    assign irq_evt[0] = mode_chg && (mode == VBLANK);
    assign irq_evt[1] = (stat_hi[3] && ly_chg && coin) ||                   // LYC
                        (stat_hi[2] && mode_chg && (mode == OAM)) ||
                        (stat_hi[1] && mode_chg && (mode == VBLANK)) ||
                        (stat_hi[0] && mode_chg && (mode == HBLANK));
    assign irq_ack    = {int_stat_ack, int_vblank_ack};

    always_ff @(posedge clk) begin
        if (rst) begin
            ly_q     <= 8'd0;
            mode_q   <= VBLANK;     // Matches mode with LCD off
            irq_req  <= 2'b00;
            irq_pend <= 2'b00;
        end else begin
            ly_q   <= ly;
            mode_q <= mode;
            for (int i = 0; i < 2; i++) begin
                if (irq_ack[i]) begin
                    irq_req[i] <= 1'b0;
                    if (irq_evt[i])
                        irq_pend[i] <= 1'b1;    // Held until ack falls
                end else if (irq_evt[i] || irq_pend[i]) begin
                    irq_req[i]  <= 1'b1;
                    irq_pend[i] <= 1'b0;
                end
            end
        end
    end

    assign int_vblank_req = irq_req[0];
    assign int_stat_req   = irq_req[1];

    a_vblank_hold: assert property (@(posedge clk) disable iff (rst)
        irq_req[0] && !irq_ack[0] |=> irq_req[0]);
    a_stat_hold: assert property (@(posedge clk) disable iff (rst)
        irq_req[1] && !irq_ack[1] |=> irq_req[1]);

endmodule

// File: rtl/ppu_timing.sv
`timescale 1ns/10ps
`include "ppu_macros.svh"

module ppu_timing import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    ppu_cfg_if.timing  cfg,
    input  logic       line_done,
    output logic       hs,
    output logic       vs,
    output logic [7:0] ly,
    output ppu_mode_e  mode,
    output logic       line_start
);
    logic [8:0] dot;
    logic [8:0] dot_nxt;
    logic [7:0] line;
    logic [7:0] line_nxt;
    ppu_mode_e  mode_q;
    ppu_mode_e  mode_nxt;

    // Free-running counters, independent of lcd_en
    always_comb begin
        dot_nxt  = dot + 9'd1;
        line_nxt = line;
        if (dot == `PPU_H_TOTAL - 1) begin
            dot_nxt  = 9'd0;
            line_nxt = (line == `PPU_V_TOTAL - 1) ? 8'd0 : line + 8'd1;
        end
    end

    // Mode for the coming dot
    always_comb begin
        if (!cfg.lcd_en || (line_nxt >= `PPU_V_ACTIVE))
            mode_nxt = VBLANK;
        else if (dot_nxt < `PPU_H_OAM)
            mode_nxt = OAM;
        else if (dot_nxt == `PPU_H_OAM)
            mode_nxt = XFER;
        else if ((mode_q == XFER) && !line_done)
            mode_nxt = XFER;            // Variable length transfer
        else
            mode_nxt = HBLANK;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dot    <= 9'd0;
            line   <= 8'd0;
            hs     <= 1'b0;
            vs     <= 1'b0;
            mode_q <= VBLANK;
        end else begin
            dot    <= dot_nxt;
            line   <= line_nxt;
            hs     <= (dot_nxt >= `PPU_H_SYNC_START) &&
                      (dot_nxt < `PPU_H_SYNC_START + `PPU_H_SYNC_LEN);
            vs     <= (line_nxt >= `PPU_V_SYNC_START) &&
                      (line_nxt < `PPU_V_SYNC_START + `PPU_V_SYNC_LEN);
            mode_q <= mode_nxt;
        end
    end

    always_comb begin
        if (cfg.lcd_en)
            mode = mode_q;
        else
            mode = VBLANK;
    end

    assign ly         = cfg.lcd_en ? line : 8'd0;
    assign line_start = (mode == XFER) && (dot == `PPU_H_OAM);   // Visible lines only

    a_dot_range: assert property (@(posedge clk) disable iff (rst) dot < `PPU_H_TOTAL);

endmodule

// File: rtl/ppu_bg_render.sv
`timescale 1ns/10ps
`include "ppu_macros.svh"

module ppu_bg_render import ppu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    ppu_cfg_if.render               cfg,
    input  logic [7:0]              ly,
    input  logic                    line_start,
    output logic [`PPU_VRAM_AW-1:0] vram_raddr,
    input  logic [7:0]              vram_rdata,
    output pix_t                    pixel,
    output logic                    valid,
    output logic                    line_done
);
    // Each byte takes an address stage (A) and a read stage (B)
    typedef enum logic [2:0] {
        F_IDLE, F_TID_A, F_TID_B, F_LO_A, F_LO_B, F_HI_A, F_HI_B
    } fetch_e;

    fetch_e                  state;
    logic                    active;
    logic                    streaming;     // Both halves filled once
    logic [4:0]              tile_cnt;
    logic [7:0]              tile_id;
    logic [7:0]              data_lo;
    tile_row_t               half [2];
    logic [1:0]              half_full;
    logic                    wr_half;
    logic                    rd_half;
    logic [2:0]              rd_pos;
    logic [7:0]              px_cnt;
    logic [7:0]              bg_y;
    logic [4:0]              map_col;
    logic [`PPU_VRAM_AW-1:0] map_addr;
    logic [`PPU_VRAM_AW-1:0] row_addr;
    tile_row_t               fetched_row;
    pix_t                    out_idx;
    logic                    fire;

    assign bg_y     = ly + cfg.scy;
    assign map_col  = tile_cnt + cfg.scx[7:3];                  // Wraps at 32
    assign map_addr = {2'b11, cfg.bg_map_sel, bg_y[7:3], map_col}; // 0x1800 or 0x1C00
    // Unsigned from 0x0000, or signed tile number around 0x1000
    assign row_addr = {~cfg.tile_data_sel & ~tile_id[7], tile_id, bg_y[2:0], 1'b0};

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            fetched_row[k] = {vram_rdata[k], data_lo[k]};  // High plane is the MSB
        end
    end

    assign out_idx = half[rd_half][~rd_pos];
    assign fire    = active && cfg.lcd_en && streaming && half_full[rd_half] &&
                     (px_cnt < `PPU_H_PIXELS);

    //////////////////////////////////////////////////////////////////////
    // Fetch control and pixel output

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= F_IDLE;
            active    <= 1'b0;
            streaming <= 1'b0;
            tile_cnt  <= 5'd0;
            half_full <= 2'b00;
            wr_half   <= 1'b0;
            rd_half   <= 1'b0;
            rd_pos    <= 3'd0;
            px_cnt    <= 8'd0;
            valid     <= 1'b0;
            pixel     <= '0;
            line_done <= 1'b0;
        end else begin
            valid     <= fire;
            line_done <= 1'b0;
            if (fire)
                pixel <= cfg.bg_en ? pix_t'(cfg.bgp[{out_idx, 1'b0} +: 2]) : pix_t'(2'd0);

            if (!cfg.lcd_en) begin
                active <= 1'b0;
                state  <= F_IDLE;
            end else if (line_start) begin
                active    <= 1'b1;
                state     <= F_TID_A;
                streaming <= 1'b0;
                tile_cnt  <= 5'd0;
                half_full <= 2'b00;
                wr_half   <= 1'b0;
                rd_half   <= 1'b0;
                rd_pos    <= 3'd0;
                px_cnt    <= 8'd0;
            end else if (active) begin
                if (px_cnt == `PPU_H_PIXELS) begin
                    active    <= 1'b0;      // Last pixel already out
                    state     <= F_IDLE;
                    line_done <= 1'b1;
                end else begin
                    if (half_full == 2'b11)
                        streaming <= 1'b1;
                    if (fire) begin
                        px_cnt <= px_cnt + 8'd1;
                        rd_pos <= rd_pos + 3'd1;
                        if (rd_pos == 3'd7) begin
                            half_full[rd_half] <= 1'b0;  // Free for refill
                            rd_half            <= ~rd_half;
                        end
                    end
                    case (state)
                        F_TID_A: if (!half_full[wr_half]) state <= F_TID_B;
                        F_TID_B: state <= F_LO_A;
                        F_LO_A:  state <= F_LO_B;
                        F_LO_B:  state <= F_HI_A;
                        F_HI_A:  state <= F_HI_B;
                        F_HI_B: begin
                            half_full[wr_half] <= 1'b1;
                            wr_half            <= ~wr_half;
                            tile_cnt           <= tile_cnt + 5'd1;
                            state              <= F_TID_A;
                        end
                        default: state <= F_IDLE;
                    endcase
                end
            end
        end
    end

    // Addresses and fetched bytes
    always_ff @(posedge clk) begin
        case (state)
            F_TID_A: if (!half_full[wr_half]) vram_raddr <= map_addr;
            F_TID_B: tile_id    <= vram_rdata;
            F_LO_A:  vram_raddr <= row_addr;
            F_LO_B:  data_lo    <= vram_rdata;
            F_HI_A:  vram_raddr <= {row_addr[`PPU_VRAM_AW-1:1], 1'b1};
            F_HI_B:  half[wr_half] <= fetched_row;
            default: ;
        endcase
    end

    a_valid_active: assert property (@(posedge clk) disable iff (rst) valid |-> active);

endmodule

// File: rtl/ppu_vram.sv
`timescale 1ns/10ps
`include "ppu_macros.svh"

module ppu_vram import ppu_pkg::*; (
    input  logic                    clk,
    input  logic [15:0]             addr,
    input  logic [7:0]              wdata,
    input  logic                    wr,
    input  ppu_mode_e               mode,
    output logic [7:0]              cpu_rdata,
    input  logic [`PPU_VRAM_AW-1:0] vram_raddr,
    output logic [7:0]              vram_rdata
);
    logic [7:0] mem [0:(1 << `PPU_VRAM_AW)-1];
    logic       in_win;
    logic       cpu_grant;

    assign in_win    = (addr >= `PPU_VRAM_BASE) && (addr <= `PPU_VRAM_LAST);
    assign cpu_grant = (mode != XFER);      // Renderer owns the RAM in mode 3

    always_ff @(posedge clk) begin
        if (wr && in_win && cpu_grant)
            mem[addr[`PPU_VRAM_AW-1:0]] <= wdata;
    end

    // Both read ports are asynchronous
    assign cpu_rdata  = (in_win && cpu_grant) ? mem[addr[`PPU_VRAM_AW-1:0]] : 8'hFF;
    assign vram_rdata = mem[vram_raddr];

endmodule

// File: rtl/ppu_top.sv
`timescale 1ns/10ps
`include "ppu_macros.svh"

module ppu_top import ppu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic [7:0]  wdata,
    input  logic        wr,
    output logic [7:0]  rdata,
    output pix_t        pixel,
    output logic        valid,
    output logic        hs,
    output logic        vs,
    output logic        int_vblank_req,
    output logic        int_stat_req,
    input  logic        int_vblank_ack,
    input  logic        int_stat_ack
);
    logic [7:0]              reg_rdata;
    logic [7:0]              vram_cpu_rdata;
    logic [7:0]              ly;
    ppu_mode_e               mode;
    logic                    line_start;
    logic                    line_done;
    logic [`PPU_VRAM_AW-1:0] vram_raddr;
    logic [7:0]              vram_rdata;

    ppu_cfg_if cfg_bus ();

    ppu_regs u_regs (
        .clk, .rst, .addr, .wdata, .wr, .reg_rdata, .cfg(cfg_bus.regs), .ly, .mode,
        .int_vblank_req, .int_stat_req, .int_vblank_ack, .int_stat_ack
    );

    ppu_timing u_timing (
        .clk, .rst, .cfg(cfg_bus.timing), .line_done, .hs, .vs, .ly, .mode, .line_start
    );

    ppu_bg_render u_render (
        .clk, .rst, .cfg(cfg_bus.render), .ly, .line_start, .vram_raddr, .vram_rdata,
        .pixel, .valid, .line_done
    );

    ppu_vram u_vram (
        .clk, .addr, .wdata, .wr, .mode, .cpu_rdata(vram_cpu_rdata), .vram_raddr, .vram_rdata
    );

    // CPU read select by window
    assign rdata = ((addr >= `PPU_REG_BASE) && (addr <= `PPU_REG_LAST))   ? reg_rdata      :
                   ((addr >= `PPU_VRAM_BASE) && (addr <= `PPU_VRAM_LAST)) ? vram_cpu_rdata :
                   8'hFF;

endmodule

// File: dv/ppu_checker.sv
`timescale 1ns/10ps
`include "ppu_macros.svh"

module ppu_checker import ppu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic [7:0]  wdata,
    input  logic        wr,
    input  logic [7:0]  rdata,
    input  pix_t        pixel,
    input  logic        valid,
    input  logic        hs,
    input  logic        vs,
    input  logic        int_vblank_req,
    input  logic        int_stat_req,
    input  logic        int_vblank_ack,
    input  logic        int_stat_ack,
    input  logic        irq_test       // Count interrupts per frame when high
);
    logic [7:0] mem [0:(1 << `PPU_VRAM_AW)-1];
    logic [7:0] regs [0:11];
    int         dot;
    int         line;
    int         pix_cnt;
    logic       line_ok;                // LCD was on when mode 3 began
    logic       vb_q, st_q, vb_ack_q, st_ack_q;
    logic       armed;
    int         vb_rises;
    int         st_rises;
    int         lines_checked = 0;
    int         irq_frames = 0;
    int         err_reg = 0;
    int         err_vram = 0;
    int         err_sync = 0;
    int         err_pix = 0;
    int         err_stat = 0;
    int         err_irq = 0;

    // Reference shade for pixel x of the current line
    function automatic pix_t bg_shade(int x);
        logic [7:0] lcdc, by, id, lo, hi;
        logic [1:0] ci;
        int         col;
        int         ta;
        lcdc = regs[0];
        by   = line[7:0] + regs[2];
        col  = ((x / 8) + (regs[3] >> 3)) % 32;
        id   = mem[32'h1800 + (lcdc[3] ? 32'h400 : 32'h0) + (by >> 3) * 32 + col];
        if (lcdc[4])
            ta = id * 16;
        else
            ta = 4096 + $signed(id) * 16;   // Signed tile number
        ta = ta + 2 * (by % 8);
        lo = mem[ta];
        hi = mem[ta + 1];
        ci = {hi[7 - x % 8], lo[7 - x % 8]};
        return lcdc[0] ? pix_t'(regs[7][2 * ci +: 2]) : pix_t'(2'd0);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Model update and comparison

    always @(posedge clk) begin
        logic [7:0] exp_v;
        logic [7:0] mask;
        logic [7:0] ly_m;
        logic       skip;
        logic       lcd;
        logic       hs_exp;
        logic       vs_exp;
        lcd  = regs[0][7];
        ly_m = lcd ? line[7:0] : 8'd0;
        if (rst) begin
            dot   <= 0;
            line  <= 0;
            armed <= 1'b0;
            for (int i = 0; i < 12; i++)
                regs[i] <= 8'h00;
            regs[7]  <= `PPU_BGP_RESET;
            pix_cnt  <= 0;
            line_ok  <= 1'b0;
            vb_rises <= 0;
            st_rises <= 0;
        end else begin
            dot <= (dot == `PPU_H_TOTAL - 1) ? 0 : dot + 1;
            if (dot == `PPU_H_TOTAL - 1)
                line <= (line == `PPU_V_TOTAL - 1) ? 0 : line + 1;

            hs_exp = (dot >= `PPU_H_SYNC_START) &&
                     (dot < `PPU_H_SYNC_START + `PPU_H_SYNC_LEN);
            vs_exp = (line >= `PPU_V_SYNC_START) &&
                     (line < `PPU_V_SYNC_START + `PPU_V_SYNC_LEN);
            if (hs !== hs_exp) begin
                $display("[FAIL] hs dot=%0d exp=%h got=%h", dot, hs_exp, hs);
                err_sync++;
            end
            if (vs !== vs_exp) begin
                $display("[FAIL] vs line=%0d exp=%h got=%h", line, vs_exp, vs);
                err_sync++;
            end

            // Bus writes into the model
            if (wr && addr >= `PPU_REG_BASE && addr <= `PPU_REG_LAST && addr[3:0] != 4'h4)
                regs[addr[3:0]] <= (addr[3:0] == 4'h1) ? (wdata & 8'hF8) : wdata;
            if (wr && addr >= `PPU_VRAM_BASE && addr <= `PPU_VRAM_LAST && !lcd)
                mem[addr[`PPU_VRAM_AW-1:0]] <= wdata;

            // CPU read data
            if (!wr) begin
                exp_v = 8'hFF;
                mask  = 8'hFF;
                skip  = 1'b0;
                if (addr >= `PPU_REG_BASE && addr <= `PPU_REG_LAST) begin
                    if (addr[3:0] == 4'h4)
                        exp_v = ly_m;
                    else if (addr[3:0] == 4'h1) begin
                        exp_v = {regs[1][7:3], ly_m == regs[5], valid ? 2'd3 : 2'd1};
                        if (lcd && !valid)
                            mask = 8'hFC;   // Mode bits only known in mode 3
                    end else
                        exp_v = regs[addr[3:0]];
                end else if (addr >= `PPU_VRAM_BASE && addr <= `PPU_VRAM_LAST) begin
                    if (!lcd || line >= `PPU_V_ACTIVE || dot < `PPU_H_OAM)
                        exp_v = mem[addr[`PPU_VRAM_AW-1:0]];
                    else if (!valid)
                        skip = 1'b1;
                end
                if (!skip && ((rdata & mask) !== (exp_v & mask))) begin
                    $display("[FAIL] rdata addr=%h exp=%h got=%h", addr, exp_v, rdata);
                    if (addr >= `PPU_VRAM_BASE && addr <= `PPU_VRAM_LAST)
                        err_vram++;
                    else if (addr == 16'hFF41 || addr == 16'hFF44)
                        err_stat++;
                    else
                        err_reg++;
                end
            end

            // Pixel stream
            if (dot == `PPU_H_OAM)
                line_ok <= lcd;
            if (valid) begin
                if (!line_ok || line >= `PPU_V_ACTIVE) begin
                    $display("valid high outside a visible line, line %0d dot %0d", line, dot);
                    err_pix++;
                end else if (pixel !== bg_shade(pix_cnt)) begin
                    $display("[FAIL] pixel line=%0d x=%0d exp=%h got=%h",
                             line, pix_cnt, bg_shade(pix_cnt), pixel);
                    err_pix++;
                end
                pix_cnt <= pix_cnt + 1;
            end else if (dot == `PPU_H_TOTAL - 1) begin
                if (line_ok && line < `PPU_V_ACTIVE) begin
                    if (pix_cnt != `PPU_H_PIXELS) begin
                        $display("[FAIL] valid count line=%0d exp=%h got=%h",
                                 line, `PPU_H_PIXELS, pix_cnt);
                        err_pix++;
                    end else
                        lines_checked++;
                end
                pix_cnt <= 0;
            end

            // Interrupt handshake and rises per frame
            if (vb_q && !int_vblank_req && !vb_ack_q) begin
                $display("int_vblank_req fell while its ack was low");
                err_irq++;
            end
            if (st_q && !int_stat_req && !st_ack_q) begin
                $display("int_stat_req fell while its ack was low");
                err_irq++;
            end
            if (line == `PPU_V_SYNC_START && dot == 0) begin
                if (armed) begin
                    irq_frames++;
                    if (vb_rises != 1) begin
                        $display("[FAIL] int_vblank_req rises exp=%h got=%h", 1, vb_rises);
                        err_irq++;
                    end
                    if (st_rises != 1) begin
                        $display("[FAIL] int_stat_req rises exp=%h got=%h", 1, st_rises);
                        err_irq++;
                    end
                end
                armed    <= irq_test;
                vb_rises <= 0;
                st_rises <= 0;
            end else begin
                if (int_vblank_req && !vb_q)
                    vb_rises <= vb_rises + 1;
                if (int_stat_req && !st_q)
                    st_rises <= st_rises + 1;
            end
        end
        vb_q     <= int_vblank_req;
        st_q     <= int_stat_req;
        vb_ack_q <= int_vblank_ack;
        st_ack_q <= int_stat_ack;
    end

endmodule

// File: dv/tb_ppu.sv
`timescale 1ns/10ps
`include "ppu_macros.svh"

module tb_ppu;
    localparam int FRAME      = `PPU_H_TOTAL * `PPU_V_TOTAL;
    localparam int N_REG      = 200;
    localparam int N_VRAM     = 400;
    localparam int BUS_CYCLES = 3 * N_REG + 2 * N_VRAM + (1 << `PPU_VRAM_AW) + 64;
    localparam int WATCH_NS   = (3 * FRAME + BUS_CYCLES) * 4;

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        wr;
    logic [7:0]  rdata;
    logic [1:0]  pixel;
    logic        valid, hs, vs;
    logic        int_vblank_req, int_stat_req;
    logic        int_vblank_ack, int_stat_ack;
    logic        irq_test;
    logic [31:0] lfsr;
    int          tests = 0;
    int          fails = 0;

    ppu_top dut (
        .clk, .rst, .addr, .wdata, .wr, .rdata, .pixel, .valid, .hs, .vs,
        .int_vblank_req, .int_stat_req, .int_vblank_ack, .int_stat_ack
    );

    ppu_checker chk (
        .clk, .rst, .addr, .wdata, .wr, .rdata, .pixel, .valid, .hs, .vs,
        .int_vblank_req, .int_stat_req, .int_vblank_ack, .int_stat_ack, .irq_test
    );

    always #2 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        addr  = a;
        wdata = d;
        wr    = 1'b1;
    endtask

    task automatic cpu_read(input logic [15:0] a);
        @(posedge clk);
        #1;
        addr = a;
        wr   = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs);
        tests++;
        fails += errs;
        if (errs == 0)
            $display("test %-20s passed", name);
        else
            $display("test %-20s %0d errors", name, errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Interrupt acknowledge, one four-phase handshake per request

    always begin
        @(posedge clk);
        #1;
        if (int_vblank_req && !int_vblank_ack) begin
            @(posedge clk);
            #1 int_vblank_ack = 1'b1;
            do begin
                @(posedge clk);
                #1;
            end while (int_vblank_req);
            int_vblank_ack = 1'b0;
        end
    end

    always begin
        @(posedge clk);
        #1;
        if (int_stat_req && !int_stat_ack) begin
            @(posedge clk);
            #1 int_stat_ack = 1'b1;
            do begin
                @(posedge clk);
                #1;
            end while (int_stat_req);
            int_stat_ack = 1'b0;
        end
    end

    initial begin
        #(WATCH_NS);
        $display("timeout: run did not finish within %0d ns", WATCH_NS);
        $display("** FAIL **");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [15:0] a;
        int          rises;
        logic        vs_q;
        clk            = 1'b0;
        rst            = 1'b1;
        addr           = 16'h0000;
        wdata          = 8'h00;
        wr             = 1'b0;
        int_vblank_ack = 1'b0;
        int_stat_ack   = 1'b0;
        irq_test       = 1'b0;
        lfsr           = 32'hfab7_2de6;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // Registers with the LCD off, plus unmapped reads
        for (int i = 0; i < N_REG; i++) begin
            take_bits(4, r);
            take_bits(8, d);
            a = 16'hFF40 + r[3:0];      // FF4C..FF4F fall outside the window
            if (r[3:0] == 4'h0)
                d[7] = 1'b0;            // Keep LCD off
            cpu_write(a, d[7:0]);
            cpu_read(a);
            take_bits(14, r);
            cpu_read(16'hA000 + r[13:0]);
        end
        report_test("register read-back", chk.err_reg);

        for (int i = 0; i < N_VRAM; i++) begin
            take_bits(13, r);
            take_bits(8, d);
            cpu_write(16'h8000 + r[12:0], d[7:0]);
            cpu_read(16'h8000 + r[12:0]);
        end

        // Random picture, then the LCD on
        for (int i = 0; i < (1 << `PPU_VRAM_AW); i++) begin
            take_bits(8, d);
            cpu_write(16'h8000 + i, d[7:0]);
        end
        take_bits(8, d);
        cpu_write(16'hFF42, d[7:0]);
        take_bits(8, d);
        cpu_write(16'hFF43, d[7:0]);
        take_bits(8, d);
        cpu_write(16'hFF47, d[7:0]);
        take_bits(8, d);
        cpu_write(16'hFF45, d[7:0] % `PPU_V_ACTIVE);
        cpu_write(16'hFF41, 8'h40);     // LYC source only
        take_bits(3, r);
        cpu_write(16'hFF40, {3'b100, r[2], r[1], 2'b00, r[0]});
        cpu_read(16'hFF40);
        irq_test = 1'b1;

        // Two frame boundaries while probing STAT, LY and VRAM
        rises = 0;
        vs_q  = 1'b0;
        while (rises < 2) begin
            take_bits(2, r);
            if (r[1:0] == 2'd0)
                a = 16'hFF41;
            else if (r[1:0] == 2'd1)
                a = 16'hFF44;
            else begin
                take_bits(13, r);
                a = 16'h8000 + r[12:0];
            end
            cpu_read(a);
            if (vs && !vs_q)
                rises++;
            vs_q = vs;
        end
        repeat (4) @(posedge clk);

        report_test("vram access", chk.err_vram);
        report_test("sync timing", chk.err_sync);
        if (chk.lines_checked < `PPU_V_ACTIVE)
            $display("only %0d complete lines were seen", chk.lines_checked);
        report_test("pixel stream", chk.err_pix + (chk.lines_checked < `PPU_V_ACTIVE));
        report_test("ly and stat", chk.err_stat);
        if (chk.irq_frames < 1)
            $display("no full frame was checked for interrupts");
        report_test("interrupts", chk.err_irq + (chk.irq_frames < 1));

        $display("tests %0d, errors %0d", tests, fails);
        if (fails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
rtl/ppu_pkg.sv
rtl/ppu_cfg_if.sv
rtl/ppu_regs.sv
rtl/ppu_timing.sv
rtl/ppu_bg_render.sv
rtl/ppu_vram.sv
rtl/ppu_top.sv
dv/ppu_checker.sv
dv/tb_ppu.sv
